// ==== video_defs.svh ====
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// Horizontal timing in clk cycles, one pixel per clock
`define H_ACTIVE     16
`define H_TOTAL      24
`define HSYNC_START  18
`define HSYNC_END    22

// Vertical timing in lines
`define V_ACTIVE     8
`define V_TOTAL      10
`define VSYNC_LINE   9

// Video RAM geometry
`define VRAM_DEPTH   1024
`define VRAM_AW      10

// APB address map
`define APB_AW       12
`define ADDR_VRAM    12'h000
`define ADDR_PAL     12'h400
`define ADDR_CTRL    12'h600
`define ADDR_BASE    12'h601

`endif

// ==== video_pkg.sv ====
package video_pkg;

    typedef logic [9:0]  vram_addr_t;
    typedef logic [7:0]  pix_idx_t;
    typedef logic [11:0] rgb_t;
    typedef logic [4:0]  hpos_t;
    typedef logic [3:0]  vpos_t;
    typedef logic [5:0]  row_t;
    typedef logic [11:0] apb_addr_t;

    // Line fetch sequencing
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DRAIN
    } render_state_t;

    // APB transfer phases, WAIT holds for video RAM
    typedef enum logic [1:0] {
        SETUP,
        ACCESS,
        WAIT
    } apb_phase_t;

endpackage

// ==== apb_regbus.sv ====
`timescale 1ns/1ps
`include "video_defs.svh"

module apb_regbus (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  video_pkg::apb_addr_t  paddr_i,
    input  logic [7:0]            pwdata_i,
    output logic [7:0]            prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    output logic                  host_req_o,
    output logic                  host_we_o,
    output video_pkg::vram_addr_t host_addr_o,
    output logic [7:0]            host_wdata_o,
    input  logic                  host_ack_i,
    input  logic [7:0]            host_rdata_i,
    output logic                  pal_we_o,
    output logic [8:0]            pal_addr_o,
    output logic [7:0]            pal_wdata_o,
    input  logic [7:0]            pal_rdata_i,
    output logic                  enable_o,
    output video_pkg::row_t       base_row_o
);
    import video_pkg::*;

    apb_phase_t phase;
    apb_phase_t phase_next;
    logic       vram_sel;
    logic       pal_sel;
    logic       ctrl_sel;
    logic       base_sel;
    logic       reg_wr;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////
    assign vram_sel = paddr_i[`APB_AW-1:`VRAM_AW] ==
                      (`APB_AW-`VRAM_AW)'(`ADDR_VRAM >> `VRAM_AW);
    assign pal_sel  = (paddr_i >= `ADDR_PAL) && (paddr_i < `ADDR_CTRL);
    assign ctrl_sel = paddr_i == `ADDR_CTRL;
    assign base_sel = paddr_i == `ADDR_BASE;

    // Video RAM and palette see the APB address and data directly
    assign host_we_o    = pwrite_i;
    assign host_addr_o  = paddr_i[`VRAM_AW-1:0];
    assign host_wdata_o = pwdata_i;
    assign pal_addr_o   = 9'(paddr_i - `ADDR_PAL);
    assign pal_wdata_o  = pwdata_i;

    ////////////////////////////////////////////////////////////////////////////
    // Transfer phases
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= SETUP;
        end else begin
            phase <= phase_next;
        end
    end

    // RAM request goes out already in the setup cycle
    always_comb begin
        host_req_o = 1'b0;
        pready_o   = 1'b0;
        phase_next = phase;
        case (phase)
            SETUP: begin
                host_req_o = psel_i && !penable_i && vram_sel;
                if (psel_i && !penable_i) begin
                    phase_next = ACCESS;
                end
            end
            ACCESS: begin
                host_req_o = vram_sel && !host_ack_i;
                pready_o   = vram_sel ? host_ack_i : 1'b1;
                phase_next = pready_o ? SETUP : WAIT;
            end
            default: begin
                host_req_o = !host_ack_i;
                pready_o   = host_ack_i;
                if (host_ack_i) begin
                    phase_next = SETUP;
                end
            end
        endcase
    end

    assign pslverr_o = pready_o && !(vram_sel || pal_sel || ctrl_sel || base_sel);
    assign reg_wr    = pready_o && psel_i && penable_i && pwrite_i;
    assign pal_we_o  = reg_wr && pal_sel;

    // Control registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable_o   <= 1'b0;
            base_row_o <= '0;
        end else if (reg_wr) begin
            if (ctrl_sel) begin
                enable_o <= pwdata_i[0];
            end
            if (base_sel) begin
                base_row_o <= row_t'(pwdata_i);
            end
        end
    end

    // Read data, unmapped reads as zero
    assign prdata_o = vram_sel ? host_rdata_i :
                      pal_sel  ? pal_rdata_i :
                      ctrl_sel ? {7'b0, enable_o} :
                      base_sel ? {2'b0, base_row_o} : 8'h00;

endmodule

// ==== video_ram.sv ====
`timescale 1ns/1ps
`include "video_defs.svh"

module video_ram (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  host_req_i,
    input  logic                  host_we_i,
    input  video_pkg::vram_addr_t host_addr_i,
    input  logic [7:0]            host_wdata_i,
    output logic                  host_ack_o,
    output logic [7:0]            host_rdata_o,
    input  logic                  ren_req_i,
    input  video_pkg::vram_addr_t ren_addr_i,
    output logic                  ren_ack_o,
    output video_pkg::pix_idx_t   ren_rdata_o
);
    import video_pkg::*;

    pix_idx_t   mem [`VRAM_DEPTH];
    pix_idx_t   rdata;
    vram_addr_t addr;
    logic       host_gnt;

    // Renderer always wins, host takes free cycles
    assign host_gnt = host_req_i && !ren_req_i;
    assign addr     = ren_req_i ? ren_addr_i : host_addr_i;

    always_ff @(posedge clk) begin
        if (host_gnt && host_we_i) begin
            mem[addr] <= host_wdata_i;
        end
        rdata <= mem[addr];
    end

    // Grant owner gets its ack with the data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ren_ack_o  <= 1'b0;
            host_ack_o <= 1'b0;
        end else begin
            ren_ack_o  <= ren_req_i;
            host_ack_o <= host_gnt;
        end
    end

    assign ren_rdata_o  = rdata;
    assign host_rdata_o = rdata;

endmodule

// ==== palette_ram.sv ====
`timescale 1ns/1ps

module palette_ram (
    input  logic                clk,
    input  logic                we_i,
    input  logic [8:0]          waddr_i,
    input  logic [7:0]          wdata_i,
    input  logic [8:0]          host_raddr_i,
    output logic [7:0]          host_rdata_o,
    input  video_pkg::pix_idx_t pix_idx_i,
    output video_pkg::rgb_t     rgb_o
);

    // Green and blue in the low lane, red in the high lane
    logic [7:0] lane_lo [256];
    logic [3:0] lane_hi [256];

    always_ff @(posedge clk) begin
        if (we_i && !waddr_i[0]) begin
            lane_lo[waddr_i[8:1]] <= wdata_i;
        end
        if (we_i && waddr_i[0]) begin
            lane_hi[waddr_i[8:1]] <= wdata_i[3:0];
        end
    end

    // Display port reads a whole entry, host port one lane
    always_ff @(posedge clk) begin
        rgb_o <= {lane_hi[pix_idx_i], lane_lo[pix_idx_i]};
        if (host_raddr_i[0]) begin
            host_rdata_o <= {4'h0, lane_hi[host_raddr_i[8:1]]};
        end else begin
            host_rdata_o <= lane_lo[host_raddr_i[8:1]];
        end
    end

endmodule

// ==== line_renderer.sv ====
`timescale 1ns/1ps
`include "video_defs.svh"

module line_renderer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  line_start_i,
    input  video_pkg::vpos_t      vpos_i,
    input  video_pkg::row_t       base_row_i,
    output logic                  ren_req_o,
    output video_pkg::vram_addr_t ren_addr_o,
    input  logic                  ren_ack_i,
    input  video_pkg::pix_idx_t   ren_rdata_i,
    output logic                  lb_wr_en_o,
    output video_pkg::hpos_t      lb_wr_idx_o,
    output video_pkg::pix_idx_t   lb_wr_data_o
);
    import video_pkg::*;

    localparam int XW = $clog2(`H_ACTIVE);

    render_state_t state;
    vpos_t         next_line;
    row_t          fetch_row;
    hpos_t         req_x;
    hpos_t         ack_x;

    // Fetch the line that is shown after the next swap
    assign next_line = (vpos_i == vpos_t'(`V_TOTAL - 1)) ? '0 : vpos_i + 1'b1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            fetch_row <= '0;
            req_x     <= '0;
            ack_x     <= '0;
        end else begin
            if (ren_ack_i) begin
                ack_x <= ack_x + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (line_start_i && next_line < vpos_t'(`V_ACTIVE)) begin
                        state     <= FETCH;
                        fetch_row <= base_row_i + row_t'(next_line);
                        req_x     <= '0;
                        ack_x     <= '0;
                    end
                end
                FETCH: begin
                    req_x <= req_x + 1'b1;
                    if (req_x == hpos_t'(`H_ACTIVE - 1)) begin
                        state <= DRAIN;
                    end
                end
                default: begin
                    // Reads still in flight
                    if (ren_ack_i && ack_x == hpos_t'(`H_ACTIVE - 1)) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Row wraps at 64, 16 bytes per row
    assign ren_req_o  = state == FETCH;
    assign ren_addr_o = vram_addr_t'({fetch_row, req_x[XW-1:0]});

    assign lb_wr_en_o   = ren_ack_i;
    assign lb_wr_idx_o  = ack_x;
    assign lb_wr_data_o = ren_rdata_i;

endmodule

// ==== line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer #(
    parameter int unsigned WIDTH_PX = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                line_start_i,
    input  logic                wr_en_i,
    input  video_pkg::hpos_t    wr_idx_i,
    input  video_pkg::pix_idx_t wr_data_i,
    input  video_pkg::hpos_t    rd_idx_i,
    output video_pkg::pix_idx_t rd_data_o
);
    import video_pkg::*;

    localparam int IW = $clog2(WIDTH_PX);

    // Scanout reads bank front_sel, renderer fills the other one
    pix_idx_t mem [2][WIDTH_PX];
    logic     front_sel;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            front_sel <= 1'b0;
        end else if (line_start_i) begin
            front_sel <= ~front_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[~front_sel][wr_idx_i[IW-1:0]] <= wr_data_i;
        end
        rd_data_o <= mem[front_sel][rd_idx_i[IW-1:0]];
    end

endmodule

// ==== pixel_scanout.sv ====
`timescale 1ns/1ps
`include "video_defs.svh"

module pixel_scanout (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable_i,
    output logic                line_start_o,
    output video_pkg::vpos_t    vpos_o,
    output video_pkg::hpos_t    lb_rd_idx_o,
    input  video_pkg::pix_idx_t lb_rd_data_i,
    output video_pkg::pix_idx_t pal_idx_o,
    input  video_pkg::rgb_t     pal_rgb_i,
    output video_pkg::rgb_t     rgb_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                de_o
);
    import video_pkg::*;

    hpos_t      hcnt;
    vpos_t      vcnt;
    logic [2:0] ctl_raw;    // de, hsync, vsync
    logic [2:0] ctl_d1;
    logic [2:0] ctl_d2;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == hpos_t'(`H_TOTAL - 1)) begin
            hcnt <= '0;
            vcnt <= (vcnt == vpos_t'(`V_TOTAL - 1)) ? '0 : vcnt + 1'b1;
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    assign line_start_o = hcnt == '0;
    assign vpos_o       = vcnt;

    // Pixel x is read at hcnt x+1, once the buffer has swapped
    assign lb_rd_idx_o = hcnt - 1'b1;
    assign pal_idx_o   = lb_rd_data_i;

    assign ctl_raw[2] = hcnt != '0 && hcnt <= hpos_t'(`H_ACTIVE) &&
                        vcnt < vpos_t'(`V_ACTIVE);
    assign ctl_raw[1] = hcnt >= hpos_t'(`HSYNC_START) && hcnt < hpos_t'(`HSYNC_END);
    assign ctl_raw[0] = vcnt == vpos_t'(`VSYNC_LINE);

    // Two stages match buffer read and palette lookup
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctl_d1  <= '0;
            ctl_d2  <= '0;
            de_o    <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            rgb_o   <= '0;
        end else begin
            ctl_d1  <= ctl_raw;
            ctl_d2  <= ctl_d1;
            de_o    <= ctl_d2[2];
            hsync_o <= ctl_d2[1];
            vsync_o <= ctl_d2[0];
            // Black outside the active area or with output disabled
            rgb_o   <= (enable_i && ctl_d2[2]) ? pal_rgb_i : '0;
        end
    end

endmodule

// ==== video_top.sv ====
`timescale 1ns/1ps

module video_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [11:0] paddr_i,
    input  logic [7:0]  pwdata_i,
    output logic [7:0]  prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic [11:0] rgb_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        de_o
);

    // Host side of video RAM
    logic       host_req;
    logic       host_we;
    logic [9:0] host_addr;
    logic [7:0] host_wdata;
    logic       host_ack;
    logic [7:0] host_rdata;

    // Renderer side of video RAM
    logic       ren_req;
    logic [9:0] ren_addr;
    logic       ren_ack;
    logic [7:0] ren_rdata;

    // Palette and control
    logic        pal_we;
    logic [8:0]  pal_addr;
    logic [7:0]  pal_wdata;
    logic [7:0]  pal_rdata;
    logic [7:0]  pal_idx;
    logic [11:0] pal_rgb;
    logic        enable;
    logic [5:0]  base_row;

    // Line timing and line buffer
    logic       line_start;
    logic [3:0] vpos;
    logic       lb_wr_en;
    logic [4:0] lb_wr_idx;
    logic [7:0] lb_wr_data;
    logic [4:0] lb_rd_idx;
    logic [7:0] lb_rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // Host access
    ////////////////////////////////////////////////////////////////////////////
    apb_regbus u_apb_regbus (
        .clk         (clk),
        .reset       (reset),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .host_req_o  (host_req),
        .host_we_o   (host_we),
        .host_addr_o (host_addr),
        .host_wdata_o(host_wdata),
        .host_ack_i  (host_ack),
        .host_rdata_i(host_rdata),
        .pal_we_o    (pal_we),
        .pal_addr_o  (pal_addr),
        .pal_wdata_o (pal_wdata),
        .pal_rdata_i (pal_rdata),
        .enable_o    (enable),
        .base_row_o  (base_row)
    );

    video_ram u_video_ram (
        .clk         (clk),
        .reset       (reset),
        .host_req_i  (host_req),
        .host_we_i   (host_we),
        .host_addr_i (host_addr),
        .host_wdata_i(host_wdata),
        .host_ack_o  (host_ack),
        .host_rdata_o(host_rdata),
        .ren_req_i   (ren_req),
        .ren_addr_i  (ren_addr),
        .ren_ack_o   (ren_ack),
        .ren_rdata_o (ren_rdata)
    );

    palette_ram u_palette_ram (
        .clk         (clk),
        .we_i        (pal_we),
        .waddr_i     (pal_addr),
        .wdata_i     (pal_wdata),
        .host_raddr_i(pal_addr),
        .host_rdata_o(pal_rdata),
        .pix_idx_i   (pal_idx),
        .rgb_o       (pal_rgb)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Display path
    ////////////////////////////////////////////////////////////////////////////
    line_renderer u_line_renderer (
        .clk         (clk),
        .reset       (reset),
        .line_start_i(line_start),
        .vpos_i      (vpos),
        .base_row_i  (base_row),
        .ren_req_o   (ren_req),
        .ren_addr_o  (ren_addr),
        .ren_ack_i   (ren_ack),
        .ren_rdata_i (ren_rdata),
        .lb_wr_en_o  (lb_wr_en),
        .lb_wr_idx_o (lb_wr_idx),
        .lb_wr_data_o(lb_wr_data)
    );

    line_buffer u_line_buffer (
        .clk         (clk),
        .reset       (reset),
        .line_start_i(line_start),
        .wr_en_i     (lb_wr_en),
        .wr_idx_i    (lb_wr_idx),
        .wr_data_i   (lb_wr_data),
        .rd_idx_i    (lb_rd_idx),
        .rd_data_o   (lb_rd_data)
    );

    pixel_scanout u_pixel_scanout (
        .clk         (clk),
        .reset       (reset),
        .enable_i    (enable),
        .line_start_o(line_start),
        .vpos_o      (vpos),
        .lb_rd_idx_o (lb_rd_idx),
        .lb_rd_data_i(lb_rd_data),
        .pal_idx_o   (pal_idx),
        .pal_rgb_i   (pal_rgb),
        .rgb_o       (rgb_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o),
        .de_o        (de_o)
    );

endmodule

// ==== video_props.sv ====
`timescale 1ns/1ps

module video_props (
    input logic clk,
    input logic reset,
    input logic psel_i,
    input logic penable_i,
    input logic pready_o,
    input logic hsync_o,
    input logic vsync_o,
    input logic de_o
);

    // Failed assertion count
    int fail_cnt = 0;

    // Ready only in an access phase
    a_ready_in_access: assert property (
        @(posedge clk) disable iff (reset) pready_o |-> (psel_i && penable_i)
    ) else begin
        $error("pready_o high outside an APB access phase");
        fail_cnt++;
    end

    // Hsync pulse is four pixel clocks wide
    a_hsync_width: assert property (
        @(posedge clk) disable iff (reset)
        $rose(hsync_o) |=> hsync_o ##1 hsync_o ##1 hsync_o ##1 !hsync_o
    ) else begin
        $error("hsync_o pulse width is not 4 cycles");
        fail_cnt++;
    end

    // No active video on the vsync line
    a_no_de_in_vsync: assert property (
        @(posedge clk) disable iff (reset) de_o |-> !vsync_o
    ) else begin
        $error("de_o high during vsync_o");
        fail_cnt++;
    end

endmodule

// ==== tb_video_checker.sv ====
`timescale 1ns/1ps
`include "video_defs.svh"

module tb_video_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [11:0] paddr_i,
    input  logic [7:0]  pwdata_i,
    input  logic [7:0]  prdata_i,
    input  logic        pready_i,
    input  logic        pslverr_i,
    input  logic [11:0] rgb_i,
    input  logic        hsync_i,
    input  logic        vsync_i,
    input  logic        de_i,
    input  logic        pix_check_i,
    output int          err_cnt_o
);

    // Model of what the host has written
    logic [7:0]  vram_m [`VRAM_DEPTH];
    logic [7:0]  pal_m [512];
    logic        en_m;
    logic [5:0]  base_m;

    // Frame bookkeeping
    int          hs_len;
    int          hs_cnt;
    int          de_len;
    int          de_runs;
    int          vs_len;
    int          px;
    int          py;
    logic        frame_seen;
    logic        prev_hs;
    logic        prev_de;
    logic        prev_vs;
    logic        unmapped;
    logic [7:0]  exp_byte;
    logic [11:0] exp_rgb;

    function automatic logic [7:0] model_read(input logic [11:0] addr);
        if (addr < `ADDR_PAL) begin
            return vram_m[addr[9:0]];
        end else if (addr < `ADDR_CTRL) begin
            return pal_m[9'(addr - `ADDR_PAL)];
        end else if (addr == `ADDR_CTRL) begin
            return {7'b0, en_m};
        end else if (addr == `ADDR_BASE) begin
            return {2'b0, base_m};
        end
        return 8'h00;
    endfunction

    // Palette entry of the VRAM byte at (x, y) of the window
    function automatic logic [11:0] model_pixel(input int x, input int y);
        logic [5:0] row;
        logic [7:0] idx;
        row = base_m + 6'(y);
        idx = vram_m[{row, 4'(x)}];
        if (!en_m) begin
            return 12'h000;
        end
        return {pal_m[{idx, 1'b1}][3:0], pal_m[{idx, 1'b0}]};
    endfunction

    initial begin
        err_cnt_o  = 0;
        en_m       = 1'b0;
        base_m     = '0;
        hs_len     = 0;
        hs_cnt     = 0;
        de_len     = 0;
        de_runs    = 0;
        vs_len     = 0;
        px         = 0;
        py         = 0;
        frame_seen = 1'b0;
        prev_hs    = 1'b0;
        prev_de    = 1'b0;
        prev_vs    = 1'b0;
    end

    always @(posedge clk) begin
        if (reset) begin
            if (pready_i || pslverr_i || de_i || hsync_i || vsync_i || rgb_i != '0) begin
                $display("Output active during reset at %0t", $time);
                err_cnt_o++;
            end
        end else begin
            //////////////////////////////////////////////////////////////////////////
            // APB transfers
            //////////////////////////////////////////////////////////////////////////
            if (psel_i && penable_i && pready_i) begin
                unmapped = paddr_i > `ADDR_BASE;
                if (pslverr_i !== unmapped) begin
                    $display("Fail %0t pslverr_o got %b expected %b", $time,
                             pslverr_i, unmapped);
                    err_cnt_o++;
                end
                if (pwrite_i) begin
                    if (paddr_i < `ADDR_PAL) begin
                        vram_m[paddr_i[9:0]] = pwdata_i;
                    end else if (paddr_i < `ADDR_CTRL) begin
                        // High lane holds only the red nibble
                        pal_m[9'(paddr_i - `ADDR_PAL)] =
                            paddr_i[0] ? {4'h0, pwdata_i[3:0]} : pwdata_i;
                    end else if (paddr_i == `ADDR_CTRL) begin
                        en_m = pwdata_i[0];
                    end else if (paddr_i == `ADDR_BASE) begin
                        base_m = pwdata_i[5:0];
                    end
                end else begin
                    exp_byte = model_read(paddr_i);
                    if (prdata_i !== exp_byte) begin
                        $display("Fail %0t prdata_o got %h expected %h (paddr %h)",
                                 $time, prdata_i, exp_byte, paddr_i);
                        err_cnt_o++;
                    end
                end
            end

            //////////////////////////////////////////////////////////////////////////
            // Video timing and picture
            //////////////////////////////////////////////////////////////////////////
            if (hsync_i) begin
                hs_len++;
            end else if (prev_hs) begin
                if (hs_len != 4) begin
                    $display("Hsync pulse lasted %0d cycles instead of 4", hs_len);
                    err_cnt_o++;
                end
                hs_cnt++;
                hs_len = 0;
            end

            if (de_i) begin
                if (pix_check_i && py < `V_ACTIVE && px < `H_ACTIVE) begin
                    exp_rgb = model_pixel(px, py);
                    if (rgb_i !== exp_rgb) begin
                        $display("Fail %0t rgb_o got %h expected %h (x %0d y %0d)",
                                 $time, rgb_i, exp_rgb, px, py);
                        err_cnt_o++;
                    end
                end
                px++;
                de_len++;
            end else if (prev_de) begin
                if (de_len != `H_ACTIVE) begin
                    $display("Active run of %0d cycles instead of %0d", de_len, `H_ACTIVE);
                    err_cnt_o++;
                end
                de_runs++;
                py++;
                px     = 0;
                de_len = 0;
            end

            if (vsync_i) begin
                if (!prev_vs) begin
                    if (frame_seen && (hs_cnt != `V_TOTAL || de_runs != `V_ACTIVE)) begin
                        $display("Frame had %0d hsync pulses and %0d active lines",
                                 hs_cnt, de_runs);
                        err_cnt_o++;
                    end
                    frame_seen = 1'b1;
                    hs_cnt     = 0;
                    de_runs    = 0;
                end
                vs_len++;
            end else if (prev_vs) begin
                if (vs_len != `H_TOTAL) begin
                    $display("Vsync lasted %0d cycles instead of one line", vs_len);
                    err_cnt_o++;
                end
                vs_len = 0;
                py     = 0;
            end

            prev_hs = hsync_i;
            prev_de = de_i;
            prev_vs = vsync_i;
        end
    end

endmodule

// ==== tb_video_top.sv ====
`timescale 1ns/1ps

module tb_video_top;

    // Run length estimate where a VRAM transfer may wait through a whole line fetch
    localparam int N_XFER       = 512 + 1024 + 2 * 150 + 120 + 4;
    localparam int XFER_CYCLES  = 8;
    localparam int N_FRAMES     = 10;
    localparam int FRAME_CYCLES = 240;
    localparam int MAX_CYCLES   = N_XFER * XFER_CYCLES + N_FRAMES * FRAME_CYCLES;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [7:0]  pwdata;
    logic [7:0]  prdata;
    logic        pready;
    logic        pslverr;
    logic [11:0] rgb;
    logic        hsync;
    logic        vsync;
    logic        de;
    logic        pix_check;
    int          err_cnt;
    int          cycles;
    logic [5:0]  base_row;

    video_top u_video_top (
        .clk      (clk),
        .reset    (reset),
        .psel_i   (psel),
        .penable_i(penable),
        .pwrite_i (pwrite),
        .paddr_i  (paddr),
        .pwdata_i (pwdata),
        .prdata_o (prdata),
        .pready_o (pready),
        .pslverr_o(pslverr),
        .rgb_o    (rgb),
        .hsync_o  (hsync),
        .vsync_o  (vsync),
        .de_o     (de)
    );

    tb_video_checker u_checker (
        .clk        (clk),
        .reset      (reset),
        .psel_i     (psel),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .paddr_i    (paddr),
        .pwdata_i   (pwdata),
        .prdata_i   (prdata),
        .pready_i   (pready),
        .pslverr_i  (pslverr),
        .rgb_i      (rgb),
        .hsync_i    (hsync),
        .vsync_i    (vsync),
        .de_i       (de),
        .pix_check_i(pix_check),
        .err_cnt_o  (err_cnt)
    );

    bind video_top video_props u_video_props (
        .clk      (clk),
        .reset    (reset),
        .psel_i   (psel_i),
        .penable_i(penable_i),
        .pready_o (pready_o),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o),
        .de_o     (de_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // One APB transfer with an idle cycle first
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [7:0] data);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) begin
            @(posedge clk);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        repeat (n) @(posedge vsync);
        @(negedge clk);
    endtask

    task automatic fill_memories();
        logic [31:0] r;
        for (int i = 0; i < 512; i++) begin
            r = $urandom;
            apb_xfer(1'b1, 12'h400 + 12'(i), r[7:0]);
        end
        for (int i = 0; i < 1024; i++) begin
            r = $urandom;
            apb_xfer(1'b1, 12'(i), r[7:0]);
        end
    endtask

    // Write then read back across all regions and unmapped space
    task automatic register_readback(input int n);
        logic [31:0] r;
        logic [31:0] a;
        logic [11:0] addr;
        for (int i = 0; i < n; i++) begin
            r = $urandom;
            a = $urandom;
            case (r[9:8])
                2'd0:    addr = {2'b00, a[9:0]};
                2'd1:    addr = 12'h400 + {3'b0, a[8:0]};
                2'd2:    addr = a[0] ? 12'h601 : 12'h600;
                default: addr = 12'h602 + {2'b0, a[9:0]};
            endcase
            apb_xfer(1'b1, addr, r[7:0]);
            apb_xfer(1'b0, addr, 8'h00);
        end
    endtask

    // VRAM reads anywhere and writes only to rows off screen
    task automatic traffic_during_render(input int n);
        logic [31:0] r;
        logic [5:0]  row;
        for (int i = 0; i < n; i++) begin
            r = $urandom;
            if (r[31]) begin
                row = base_row + 6'd8 + 6'(r[15:8] % 56);
                apb_xfer(1'b1, {2'b00, row, r[19:16]}, r[7:0]);
            end else begin
                apb_xfer(1'b0, {2'b00, r[9:0]}, 8'h00);
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        int          total;
        cycles    = 0;
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pix_check = 1'b0;
        r         = $urandom(32'h25fa_d116);
        repeat (16) @(negedge clk);
        reset = 1'b0;

        fill_memories();
        register_readback(150);

        // Picture with a random start row
        r        = $urandom;
        base_row = r[5:0];
        apb_xfer(1'b1, 12'h601, {2'b00, base_row});
        apb_xfer(1'b1, 12'h600, 8'h01);
        wait_frames(2);
        pix_check = 1'b1;
        wait_frames(2);

        traffic_during_render(120);
        wait_frames(1);

        // Output disabled so the picture must be black
        pix_check = 1'b0;
        apb_xfer(1'b1, 12'h600, 8'h00);
        wait_frames(1);
        pix_check = 1'b1;
        wait_frames(1);
        pix_check = 1'b0;

        total = err_cnt + u_video_top.u_video_props.fail_cnt;
        $display("Run ended after %0d cycles with %0d checker errors and %0d assertion errors",
                 cycles, err_cnt, u_video_top.u_video_props.fail_cnt);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
video_pkg.sv
apb_regbus.sv
video_ram.sv
palette_ram.sv
line_renderer.sv
line_buffer.sv
pixel_scanout.sv
video_top.sv
video_props.sv
tb_video_checker.sv
tb_video_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

verilator --binary --timing --assert -f sources.f --top-module tb_video_top \
    -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
